/* loopback_input.txt */
# tx_word(hex) payload_bits recharge_len wait_step holdoff_len tx_disable
# One test per line, fields after the hex word are decimal
a5c30f1e 4 3 4 6 0
ffffffff 1 1 1 1 0
00000000 2 2 3 2 0
12345678 3 1 2 5 1
80000001 5 2 6 3 0
3c96e14b 2 4 1 4 1
0f0f0f0f 1 6 8 2 0
9e3779b9 6 1 2 1 0
5a5a5a5a 3 3 3 3 1
76543210 2 5 10 7 0
13579bdf 7 2 2 2 0
fedcba98 1 1 1 1 1
00010002 4 2 5 9 0
7fffffff 2 3 2 2 0

/* vlog.f */
mrr_timing_pkg.sv
decode_word_pkg.sv
mrr_cycle_timer.sv
loopback_fsm.sv
symbol_accumulator.sv
decoded_output_mux.sv
mrr_loopback_top.sv
tb_mrr_loopback_sva.sv
tb_mrr_loopback.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the loopback testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
    --top-module tb_mrr_loopback -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "TEST FAILED" "$LOG"; then
    exit 1
fi
exit 0

/* tb_mrr_loopback.sv */
`timescale 1ns/10ps

module tb_mrr_loopback;
    import mrr_timing_pkg::*;
    import decode_word_pkg::*;

    localparam int MAX_TESTS = 32;

    // Phases of the reference model
    localparam int PH_READY = 0;
    localparam int PH_RX    = 1;
    localparam int PH_TA    = 2;
    localparam int PH_TX    = 3;
    localparam int PH_HO    = 4;
    localparam int PH_META  = 5;

    logic          clk;
    logic          rst;
    logic          i_fm_flag;
    logic          i_tx_disable;
    logic [31:0]   i_tx_word;
    logic [7:0]    i_num_payload_bits;
    logic [14:0]   i_recharge_len;
    logic [15:0]   i_wait_step;
    logic [15:0]   i_holdoff_len;
    sample_t       i_sample;
    logic          i_sample_valid;
    logic          i_sample_keep;
    logic [31:0]   i_cfo_idx;
    logic [31:0]   i_sfo_idx;
    logic [63:0]   i_cur_time;
    logic [31:0]   i_cur_corr;
    logic [63:0]   i_cur_metadata;
    decoded_word_t o_decoded_data;
    logic          o_decoded_valid;
    logic          o_decoded_last;
    logic          o_tx_en;
    logic          o_tx_pulse;
    logic          o_detector_reset;
    logic          o_currently_decoding;

    // Test table read from the input file
    logic [31:0] t_word [MAX_TESTS];
    int          t_bits [MAX_TESTS];
    int          t_rech [MAX_TESTS];
    int          t_wait [MAX_TESTS];
    int          t_hold [MAX_TESTS];
    int          t_dis  [MAX_TESTS];
    int          num_tests   = 0;
    int          cycle_count = 0;
    int          cycle_limit = 0;
    int          errors      = 0;
    int          checks      = 0;

    // Reference model state after the last rising edge
    int           ph            = PH_READY;
    int           samp          = 0;
    int           cyc           = 0;
    int           bitn          = 0;
    int           meta_idx      = 0;
    int           sym_seen      = 0;
    logic [27:0]  exp_sum       = '0;
    logic [3:0]   exp_cnt       = '0;
    logic         exp_sym_valid = 1'b0;
    logic         exp_sym_last  = 1'b0;
    soft_symbol_t exp_sym       = '0;
    logic [31:0]  meta_words [NUM_METADATA];

    mrr_loopback_top uut (
        .clk                  (clk),
        .rst                  (rst),
        .i_fm_flag            (i_fm_flag),
        .i_tx_disable         (i_tx_disable),
        .i_tx_word            (i_tx_word),
        .i_num_payload_bits   (i_num_payload_bits),
        .i_recharge_len       (i_recharge_len),
        .i_wait_step          (i_wait_step),
        .i_holdoff_len        (i_holdoff_len),
        .i_sample             (i_sample),
        .i_sample_valid       (i_sample_valid),
        .i_sample_keep        (i_sample_keep),
        .i_cfo_idx            (i_cfo_idx),
        .i_sfo_idx            (i_sfo_idx),
        .i_cur_time           (i_cur_time),
        .i_cur_corr           (i_cur_corr),
        .i_cur_metadata       (i_cur_metadata),
        .o_decoded_data       (o_decoded_data),
        .o_decoded_valid      (o_decoded_valid),
        .o_decoded_last       (o_decoded_last),
        .o_tx_en              (o_tx_en),
        .o_tx_pulse           (o_tx_pulse),
        .o_detector_reset     (o_detector_reset),
        .o_currently_decoding (o_currently_decoding)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_limit != 0 && cycle_count >= cycle_limit) begin
            $display("Timeout: run stopped at cycle %0d before all tests finished", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_symbol(input soft_symbol_t got, input soft_symbol_t exp,
                                input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got count 0x%h sum 0x%h, expected count 0x%h sum 0x%h",
                     name, got.count, got.sum, exp.count, exp.sum);
        end
    endtask

    task automatic check_word(input logic [31:0] got, input logic [31:0] exp,
                              input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%08h expected 0x%08h", name, got, exp);
        end
    endtask

    task automatic check_bit(input logic got, input logic exp, input string name);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH %s: got 0x%h expected 0x%h at cycle %0d",
                     name, got, exp, cycle_count);
        end
    endtask

    function automatic int phase_period(input int p, input int t);
        case (p)
            PH_RX:   return t_rech[t] + 2;
            PH_TA:   return t_wait[t];
            PH_TX:   return TX_CYCLES_PER_BIT;
            default: return t_hold[t];
        endcase
    endfunction

    function automatic int phase_bits(input int p, input int t);
        case (p)
            PH_RX:   return t_bits[t];
            PH_TX:   return TX_BITS;
            default: return 1;
        endcase
    endfunction

    task automatic check_outputs(input int t);
        logic exp_tx_en;
        logic exp_pulse;
        int   pulse_at;
        exp_tx_en = (ph == PH_TX) && (t_dis[t] == 0);
        pulse_at  = t_word[t][bitn % 32] ? TX_ONE_CYCLE : TX_ZERO_CYCLE;
        exp_pulse = exp_tx_en && (cyc == pulse_at);
        // Soft symbols the DUT actually delivered
        if (ph != PH_META && o_decoded_valid === 1'b1) begin
            sym_seen++;
        end
        check_bit(o_currently_decoding, ph != PH_READY, "o_currently_decoding");
        check_bit(o_detector_reset, (ph == PH_TX) || (ph == PH_HO), "o_detector_reset");
        check_bit(o_tx_en, exp_tx_en, "o_tx_en");
        check_bit(o_tx_pulse, exp_pulse, "o_tx_pulse");
        check_bit(o_decoded_valid, exp_sym_valid || (ph == PH_META), "o_decoded_valid");
        if (ph == PH_META) begin
            check_word(o_decoded_data.meta, meta_words[meta_idx], "o_decoded_data.meta");
            check_bit(o_decoded_last, meta_idx == NUM_METADATA - 1, "o_decoded_last");
        end else if (exp_sym_valid) begin
            check_symbol(o_decoded_data.symbol, exp_sym, "o_decoded_data.symbol");
            check_bit(o_decoded_last, exp_sym_last, "o_decoded_last");
        end else begin
            check_bit(o_decoded_last, 1'b0, "o_decoded_last");
        end
    endtask

    // Advance the model over one rising edge with the inputs just driven
    task automatic step_model(input int t, input logic accept, input logic fm, input sample_t s);
        int per;
        per = phase_period(ph, t);
        exp_sym_valid = 1'b0;
        if (ph == PH_READY) begin
            if (fm) begin
                ph       = PH_RX;
                samp     = 0;
                cyc      = 0;
                bitn     = 0;
                exp_sum  = '0;
                exp_cnt  = '0;
            end
        end else if (ph == PH_META) begin
            if (meta_idx == NUM_METADATA - 1) begin
                ph = PH_READY;
            end else begin
                meta_idx++;
            end
        end else if (accept) begin
            if (ph == PH_RX) begin
                exp_sum = exp_sum + 28'(s);
                exp_cnt = exp_cnt + 4'd1;
            end
            if (samp == SAMPLES_PER_CYCLE - 1) begin
                samp = 0;
                if (ph == PH_RX) begin
                    exp_sym.count = exp_cnt;
                    exp_sym.sum   = exp_sum;
                    exp_sym_valid = 1'b1;
                    exp_sym_last  = (cyc == per - 1);
                    exp_sum       = '0;
                    exp_cnt       = '0;
                end
                if (cyc == per - 1) begin
                    cyc = 0;
                    bitn++;
                    if (bitn == phase_bits(ph, t)) begin
                        ph       = ph + 1;
                        bitn     = 0;
                        meta_idx = 0;
                    end
                end else begin
                    cyc++;
                end
            end else begin
                samp++;
            end
        end
    endtask

    task automatic read_tests();
        int          fd;
        int          n;
        string       line;
        logic [31:0] w;
        int          b;
        int          r;
        int          ws;
        int          h;
        int          d;
        fd = $fopen("loopback_input.txt", "r");
        if (fd != 0) begin
            while (!$feof(fd) && num_tests < MAX_TESTS) begin
                n = $fgets(line, fd);
                if (n > 0 && line.getc(0) != "#") begin
                    n = $sscanf(line, "%h %d %d %d %d %d", w, b, r, ws, h, d);
                    if (n == 6) begin
                        t_word[num_tests] = w;
                        t_bits[num_tests] = b;
                        t_rech[num_tests] = r;
                        t_wait[num_tests] = ws;
                        t_hold[num_tests] = h;
                        t_dis[num_tests]  = d;
                        num_tests++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic run_test(input int t);
        int      err_start;
        logic    v;
        logic    k;
        sample_t s;
        err_start = errors;
        sym_seen  = 0;
        @(negedge clk);
        check_outputs(t);
        i_tx_word          = t_word[t];
        i_num_payload_bits = 8'(t_bits[t]);
        i_recharge_len     = 15'(t_rech[t]);
        i_wait_step        = 16'(t_wait[t]);
        i_holdoff_len      = 16'(t_hold[t]);
        i_tx_disable       = (t_dis[t] != 0);
        i_cfo_idx          = $urandom;
        i_sfo_idx          = $urandom;
        i_cur_time         = {$urandom, $urandom};
        i_cur_corr         = $urandom;
        i_cur_metadata     = {$urandom, $urandom};
        meta_words[0] = i_cfo_idx;
        meta_words[1] = i_sfo_idx;
        meta_words[2] = i_cur_time[63:32];
        meta_words[3] = i_cur_time[31:0];
        meta_words[4] = i_cur_corr;
        meta_words[5] = i_cur_metadata[63:32];
        meta_words[6] = i_cur_metadata[31:0];
        i_sample_valid = 1'b0;
        i_fm_flag      = 1'b1;
        step_model(t, 1'b0, 1'b1, '0);
        while (ph != PH_READY) begin
            @(negedge clk);
            check_outputs(t);
            i_fm_flag = 1'b0;
            // Roughly 70% of clocks carry an accepted sample
            v = ($urandom % 10) < 8;
            k = ($urandom % 8) != 0;
            s = sample_t'($urandom);
            i_sample_valid = v;
            i_sample_keep  = k;
            i_sample       = s;
            step_model(t, v && k, 1'b0, s);
        end
        @(negedge clk);
        check_outputs(t);
        check_word(32'(sym_seen), 32'(t_bits[t] * (t_rech[t] + 2)), "soft symbol count");
        if (errors == err_start) begin
            $display("test %0d: word=%08h bits=%0d rech=%0d wait=%0d hold=%0d dis=%0d ok",
                     t, t_word[t], t_bits[t], t_rech[t], t_wait[t], t_hold[t], t_dis[t]);
        end else begin
            $display("test %0d: word=%08h bits=%0d rech=%0d wait=%0d hold=%0d dis=%0d, %0d errors",
                     t, t_word[t], t_bits[t], t_rech[t], t_wait[t], t_hold[t], t_dis[t],
                     errors - err_start);
        end
    endtask

    initial begin
        void'($urandom(32'hae6c));
        rst                = 1'b1;
        i_fm_flag          = 1'b0;
        i_tx_disable       = 1'b0;
        i_tx_word          = '0;
        i_num_payload_bits = '0;
        i_recharge_len     = '0;
        i_wait_step        = '0;
        i_holdoff_len      = '0;
        i_sample           = '0;
        i_sample_valid     = 1'b0;
        i_sample_keep      = 1'b0;
        i_cfo_idx          = '0;
        i_sfo_idx          = '0;
        i_cur_time         = '0;
        i_cur_corr         = '0;
        i_cur_metadata     = '0;
        read_tests();
        if (num_tests == 0) begin
            $display("No tests could be read from loopback_input.txt");
            $display("TEST FAILED");
            $finish;
        end else begin
            for (int t = 0; t < num_tests; t++) begin
                cycle_limit += 2 * 2 * 8 *
                    (t_bits[t] * (t_rech[t] + 2) + t_wait[t] + 160 + t_hold[t]);
            end
            cycle_limit += 1000;
            repeat (16) @(negedge clk);
            rst = 1'b0;
            @(negedge clk);
            check_outputs(0);
            if (errors == 0) begin
                $display("reset: control outputs low, ok");
            end else begin
                $display("reset: %0d errors", errors);
            end
            for (int t = 0; t < num_tests; t++) begin
                run_test(t);
            end
            $display("tests=%0d checks=%0d errors=%0d", num_tests, checks, errors);
            if (errors == 0) begin
                $display("TEST PASSED");
            end else begin
                $display("TEST FAILED");
            end
            $finish;
        end
    end

endmodule

/* tb_mrr_loopback_sva.sv */
`timescale 1ns/10ps

module tb_mrr_loopback_sva (
    input logic clk,
    input logic rst,
    input logic i_tx_pulse,
    input logic i_tx_en,
    input logic i_detector_reset,
    input logic i_decoded_valid
);

    // Pulses only go out while the modulator is enabled
    tx_pulse_needs_en: assert property (@(posedge clk) disable iff (rst)
        i_tx_pulse |-> i_tx_en)
        else $error("o_tx_pulse high while o_tx_en is low");

    // Detector stays in reset for the whole transmission
    tx_en_holds_detector: assert property (@(posedge clk) disable iff (rst)
        i_tx_en |-> i_detector_reset)
        else $error("o_tx_en high without o_detector_reset");

    // No decoded word can appear while transmitting
    no_decode_during_tx: assert property (@(posedge clk) disable iff (rst)
        !(i_decoded_valid && i_tx_en))
        else $error("o_decoded_valid high while o_tx_en is high");

endmodule

bind mrr_loopback_top tb_mrr_loopback_sva u_sva (
    .clk              (clk),
    .rst              (rst),
    .i_tx_pulse       (o_tx_pulse),
    .i_tx_en          (o_tx_en),
    .i_detector_reset (o_detector_reset),
    .i_decoded_valid  (o_decoded_valid)
);

/* mrr_loopback_top.sv */
`timescale 1ns/10ps

module mrr_loopback_top (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           i_fm_flag,
    input  logic                           i_tx_disable,
    input  logic [31:0]                    i_tx_word,
    input  logic [7:0]                     i_num_payload_bits,
    input  logic [14:0]                    i_recharge_len,
    input  logic [15:0]                    i_wait_step,
    input  logic [15:0]                    i_holdoff_len,
    input  decode_word_pkg::sample_t       i_sample,
    input  logic                           i_sample_valid,
    input  logic                           i_sample_keep,
    input  logic [31:0]                    i_cfo_idx,
    input  logic [31:0]                    i_sfo_idx,
    input  logic [63:0]                    i_cur_time,
    input  logic [31:0]                    i_cur_corr,
    input  logic [63:0]                    i_cur_metadata,
    output decode_word_pkg::decoded_word_t o_decoded_data,
    output logic                           o_decoded_valid,
    output logic                           o_decoded_last,
    output logic                           o_tx_en,
    output logic                           o_tx_pulse,
    output logic                           o_detector_reset,
    output logic                           o_currently_decoding
);
    import mrr_timing_pkg::*;
    import decode_word_pkg::*;

    wire           sample_accept = i_sample_valid && i_sample_keep;
    cycle_idx_t    cycle_idx;
    cycle_idx_t    cycles_per_bit;
    bit_count_t    bit_count;
    logic          cycle_end;
    logic          bit_end;
    logic          timer_clear;
    logic          accum_en;
    logic          meta_active;
    logic          meta_done;
    soft_symbol_t  symbol;
    logic          symbol_valid;

    mrr_cycle_timer u_timer (
        .clk              (clk),
        .rst              (rst),
        .i_sample_accept  (sample_accept),
        .i_clear          (timer_clear),
        .i_cycles_per_bit (cycles_per_bit),
        .o_cycle_idx      (cycle_idx),
        .o_cycle_end      (cycle_end),
        .o_bit_end        (bit_end),
        .o_bit_count      (bit_count)
    );

    loopback_fsm u_fsm (
        .clk                  (clk),
        .rst                  (rst),
        .i_fm_flag            (i_fm_flag),
        .i_tx_disable         (i_tx_disable),
        .i_tx_word            (i_tx_word),
        .i_num_payload_bits   (i_num_payload_bits),
        .i_recharge_len       (i_recharge_len),
        .i_wait_step          (i_wait_step),
        .i_holdoff_len        (i_holdoff_len),
        .i_cycle_idx          (cycle_idx),
        .i_bit_end            (bit_end),
        .i_bit_count          (bit_count),
        .i_meta_done          (meta_done),
        .o_timer_clear        (timer_clear),
        .o_cycles_per_bit     (cycles_per_bit),
        .o_accum_en           (accum_en),
        .o_meta_active        (meta_active),
        .o_tx_en              (o_tx_en),
        .o_tx_pulse           (o_tx_pulse),
        .o_detector_reset     (o_detector_reset),
        .o_currently_decoding (o_currently_decoding)
    );

    symbol_accumulator u_accum (
        .clk             (clk),
        .rst             (rst),
        .i_sample        (i_sample),
        .i_sample_accept (sample_accept),
        .i_accum_en      (accum_en),
        .i_cycle_end     (cycle_end),
        .o_symbol        (symbol),
        .o_symbol_valid  (symbol_valid)
    );

    decoded_output_mux u_out (
        .clk             (clk),
        .rst             (rst),
        .i_symbol        (symbol),
        .i_symbol_valid  (symbol_valid),
        .i_bit_end       (bit_end),
        .i_meta_active   (meta_active),
        .i_cfo_idx       (i_cfo_idx),
        .i_sfo_idx       (i_sfo_idx),
        .i_cur_time      (i_cur_time),
        .i_cur_corr      (i_cur_corr),
        .i_cur_metadata  (i_cur_metadata),
        .o_decoded_data  (o_decoded_data),
        .o_decoded_valid (o_decoded_valid),
        .o_decoded_last  (o_decoded_last),
        .o_meta_done     (meta_done)
    );

endmodule

/* decoded_output_mux.sv */
`timescale 1ns/10ps

module decoded_output_mux (
    input  logic                           clk,
    input  logic                           rst,
    input  decode_word_pkg::soft_symbol_t  i_symbol,
    input  logic                           i_symbol_valid,
    input  logic                           i_bit_end,
    input  logic                           i_meta_active,
    input  logic [31:0]                    i_cfo_idx,
    input  logic [31:0]                    i_sfo_idx,
    input  logic [63:0]                    i_cur_time,
    input  logic [31:0]                    i_cur_corr,
    input  logic [63:0]                    i_cur_metadata,
    output decode_word_pkg::decoded_word_t o_decoded_data,
    output logic                           o_decoded_valid,
    output logic                           o_decoded_last,
    output logic                           o_meta_done
);
    import decode_word_pkg::*;

    metadata_idx_t meta_idx;
    logic          bit_end_d;
    logic [31:0]   meta_word;

    always_ff @(posedge clk) begin
        if (rst) begin
            meta_idx  <= '0;
            bit_end_d <= 1'b0;
        end else begin
            // Lines up with the registered symbol of the same cycle
            bit_end_d <= i_bit_end;
            if (i_meta_active) begin
                meta_idx <= meta_idx + 3'd1;
            end else begin
                meta_idx <= '0;
            end
        end
    end

    always_comb begin
        case (meta_idx)
            3'd0:    meta_word = i_cfo_idx;
            3'd1:    meta_word = i_sfo_idx;
            3'd2:    meta_word = i_cur_time[63:32];
            3'd3:    meta_word = i_cur_time[31:0];
            3'd4:    meta_word = i_cur_corr;
            3'd5:    meta_word = i_cur_metadata[63:32];
            default: meta_word = i_cur_metadata[31:0];
        endcase
    end

    always_comb begin
        o_decoded_data = '0;
        if (i_meta_active) begin
            o_decoded_data.meta = meta_word;
        end else begin
            o_decoded_data.symbol = i_symbol;
        end
    end

    assign o_meta_done     = i_meta_active && (meta_idx == metadata_idx_t'(NUM_METADATA - 1));
    assign o_decoded_valid = i_symbol_valid || i_meta_active;
    assign o_decoded_last  = (i_symbol_valid && bit_end_d) || o_meta_done;

endmodule

/* symbol_accumulator.sv */
`timescale 1ns/10ps

module symbol_accumulator (
    input  logic                          clk,
    input  logic                          rst,
    input  decode_word_pkg::sample_t      i_sample,
    input  logic                          i_sample_accept,
    input  logic                          i_accum_en,
    input  logic                          i_cycle_end,
    output decode_word_pkg::soft_symbol_t o_symbol,
    output logic                          o_symbol_valid
);
    import decode_word_pkg::*;

    soft_symbol_t running;
    logic         take;
    logic         close;
    logic [27:0]  sum_next;
    logic [3:0]   count_next;

    assign take  = i_accum_en && i_sample_accept;
    assign close = take && i_cycle_end;

    // Totals including the sample on this edge
    assign sum_next   = running.sum + 28'(i_sample);
    assign count_next = running.count + 4'd1;

    always_ff @(posedge clk) begin
        if (rst) begin
            running        <= '0;
            o_symbol_valid <= 1'b0;
        end else begin
            o_symbol_valid <= close;
            if (!i_accum_en || close) begin
                running <= '0;
            end else if (take) begin
                running.sum   <= sum_next;
                running.count <= count_next;
            end
        end
    end

    // Result of the completed cycle
    always_ff @(posedge clk) begin
        if (close) begin
            o_symbol.sum   <= sum_next;
            o_symbol.count <= count_next;
        end
    end

endmodule

/* loopback_fsm.sv */
`timescale 1ns/10ps

module loopback_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_fm_flag,
    input  logic                       i_tx_disable,
    input  logic [31:0]                i_tx_word,
    input  logic [7:0]                 i_num_payload_bits,
    input  logic [14:0]                i_recharge_len,
    input  logic [15:0]                i_wait_step,
    input  logic [15:0]                i_holdoff_len,
    input  mrr_timing_pkg::cycle_idx_t i_cycle_idx,
    input  logic                       i_bit_end,
    input  mrr_timing_pkg::bit_count_t i_bit_count,
    input  logic                       i_meta_done,
    output logic                       o_timer_clear,
    output mrr_timing_pkg::cycle_idx_t o_cycles_per_bit,
    output logic                       o_accum_en,
    output logic                       o_meta_active,
    output logic                       o_tx_en,
    output logic                       o_tx_pulse,
    output logic                       o_detector_reset,
    output logic                       o_currently_decoding
);
    import mrr_timing_pkg::*;

    localparam logic [2:0] ST_READY      = 3'd0;
    localparam logic [2:0] ST_RECEIVE    = 3'd1;
    localparam logic [2:0] ST_TURNAROUND = 3'd2;
    localparam logic [2:0] ST_TRANSMIT   = 3'd3;
    localparam logic [2:0] ST_HOLDOFF    = 3'd4;
    localparam logic [2:0] ST_METADATA   = 3'd5;

    logic [2:0] state;
    logic [2:0] next_state;
    bit_count_t last_bit;
    logic       phase_done;
    logic       tx_bit;
    cycle_idx_t pulse_cycle;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= ST_READY;
        end else begin
            state <= next_state;
        end
    end

    // Bit period length and bit total of each timed phase
    always_comb begin
        o_cycles_per_bit = 16'd1;
        last_bit         = '0;
        case (state)
            ST_RECEIVE: begin
                o_cycles_per_bit = {1'b0, i_recharge_len} + 16'd2;
                last_bit         = i_num_payload_bits - 8'd1;
            end
            ST_TURNAROUND: begin
                // Whole wait is a single long bit
                o_cycles_per_bit = i_wait_step;
            end
            ST_TRANSMIT: begin
                o_cycles_per_bit = cycle_idx_t'(TX_CYCLES_PER_BIT);
                last_bit         = bit_count_t'(TX_BITS - 1);
            end
            ST_HOLDOFF: begin
                o_cycles_per_bit = i_holdoff_len;
            end
            default: begin
                o_cycles_per_bit = 16'd1;
            end
        endcase
    end

    assign phase_done = i_bit_end && (i_bit_count == last_bit);

    always_comb begin
        next_state = state;
        case (state)
            ST_READY: begin
                if (i_fm_flag) begin
                    next_state = ST_RECEIVE;
                end
            end
            ST_RECEIVE: begin
                if (phase_done) begin
                    next_state = ST_TURNAROUND;
                end
            end
            ST_TURNAROUND: begin
                if (phase_done) begin
                    next_state = ST_TRANSMIT;
                end
            end
            ST_TRANSMIT: begin
                if (phase_done) begin
                    next_state = ST_HOLDOFF;
                end
            end
            ST_HOLDOFF: begin
                if (phase_done) begin
                    next_state = ST_METADATA;
                end
            end
            ST_METADATA: begin
                if (i_meta_done) begin
                    next_state = ST_READY;
                end
            end
            default: begin
                next_state = ST_READY;
            end
        endcase
    end

    // Timer stays idle outside the timed phases and restarts on every change
    assign o_timer_clear = (state == ST_READY) || (state == ST_METADATA) ||
                           (next_state != state);

    assign o_accum_en           = (state == ST_RECEIVE);
    assign o_meta_active        = (state == ST_METADATA);
    assign o_detector_reset     = (state == ST_TRANSMIT) || (state == ST_HOLDOFF);
    assign o_currently_decoding = (state != ST_READY);
    assign o_tx_en              = (state == ST_TRANSMIT) && !i_tx_disable;

    // Transmit bit count selects the word bit so the LSB goes out first
    assign tx_bit      = i_tx_word[i_bit_count[4:0]];
    assign pulse_cycle = tx_bit ? cycle_idx_t'(TX_ONE_CYCLE) : cycle_idx_t'(TX_ZERO_CYCLE);
    assign o_tx_pulse  = o_tx_en && (i_cycle_idx == pulse_cycle);

endmodule

/* mrr_cycle_timer.sv */
`timescale 1ns/10ps

module mrr_cycle_timer (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       i_sample_accept,
    input  logic                       i_clear,
    input  mrr_timing_pkg::cycle_idx_t i_cycles_per_bit,
    output mrr_timing_pkg::cycle_idx_t o_cycle_idx,
    output logic                       o_cycle_end,
    output logic                       o_bit_end,
    output mrr_timing_pkg::bit_count_t o_bit_count
);
    import mrr_timing_pkg::*;

    sample_phase_t sample_phase;
    cycle_idx_t    cycle_idx;
    bit_count_t    bit_count;

    // The eighth accepted sample closes the cycle
    assign o_cycle_end = i_sample_accept &&
                         (sample_phase == sample_phase_t'(SAMPLES_PER_CYCLE - 1));

    // Last cycle of the bit period closes the bit
    assign o_bit_end = o_cycle_end && (cycle_idx == i_cycles_per_bit - 16'd1);

    assign o_cycle_idx = cycle_idx;
    assign o_bit_count = bit_count;

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_phase <= '0;
            cycle_idx    <= '0;
            bit_count    <= '0;
        end else if (i_clear) begin
            // Clear has priority so a new phase starts at cycle 0, bit 0
            sample_phase <= '0;
            cycle_idx    <= '0;
            bit_count    <= '0;
        end else if (i_sample_accept) begin
            if (o_cycle_end) begin
                sample_phase <= '0;
            end else begin
                sample_phase <= sample_phase + 3'd1;
            end

            if (o_bit_end) begin
                cycle_idx <= '0;
                bit_count <= bit_count + 8'd1;
            end else if (o_cycle_end) begin
                cycle_idx <= cycle_idx + 16'd1;
            end
        end
    end

endmodule

/* decode_word_pkg.sv */
package decode_word_pkg;

    // Unsigned envelope sample from the detector
    typedef logic [15:0] sample_t;

    // Energy of one MRR cycle with the sample count on top
    typedef struct packed {
        logic [3:0]  count;
        logic [27:0] sum;
    } soft_symbol_t;

    // Host reads a soft symbol during receive and a plain word during metadata
    typedef union packed {
        soft_symbol_t symbol;
        logic [31:0]  meta;
    } decoded_word_t;

    // CFO, SFO, time hi/lo, correlation, metadata hi/lo
    localparam int NUM_METADATA = 7;

    typedef logic [2:0] metadata_idx_t;

endpackage

/* mrr_timing_pkg.sv */
package mrr_timing_pkg;

    // Accepted envelope samples that make up one MRR cycle
    localparam int SAMPLES_PER_CYCLE = 8;

    // Loopback transmit word
    localparam int TX_BITS           = 32;
    localparam int TX_CYCLES_PER_BIT = 5;

    // Cycle within a transmit bit that carries the position-coded pulse
    localparam int TX_ONE_CYCLE      = 0;
    localparam int TX_ZERO_CYCLE     = 2;

    // MRR cycle index within the current bit period
    typedef logic [15:0] cycle_idx_t;

    // Sample position within an MRR cycle
    typedef logic [2:0] sample_phase_t;

    // Bits completed in the current phase
    typedef logic [7:0] bit_count_t;

endpackage
